/* arcade_in_pkg.sv */
// Shared types and constants for the arcade player-input front end
// Player word layout, keyboard and analog structs, APB register map
package arcade_in_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int NUM_PLAYERS = 4;
    localparam int DIP_W       = 8;        // One DIP bank

    // Player word bit positions
    localparam int DIR_RIGHT = 0;
    localparam int DIR_LEFT  = 1;
    localparam int BTN_START = 10;
    localparam int BTN_COIN  = 11;
    localparam int BTN_PAUSE = 12;

    // [3:0] right/left/down/up, [9:4] buttons, [13:10] start/coin/pause/savestate
    typedef logic [15:0] player_word_t;

    typedef struct packed {
        logic       coin;
        logic       start;
        logic [7:0] btn;                   // Lands on player word [7:0]
    } kb_player_t;

    // ========================================
    // Analog
    // ========================================
    typedef struct packed {
        logic [8:0] spinner;               // Bit 8 toggles on each new delta
        logic [7:0] paddle;
        logic [7:0] stick_x;
    } analog_src_t;

    localparam logic [1:0] ANA_STICK   = 2'd0;
    localparam logic [1:0] ANA_PADDLE  = 2'd1;
    localparam logic [1:0] ANA_SPINNER = 2'd2;
    localparam logic [1:0] ANA_DPAD    = 2'd3;

    typedef struct packed {
        logic       invert;
        logic [2:0] sens;
        logic [1:0] mode;                  // Byte bits [1:0] in the register
    } analog_cfg_t;

    typedef struct packed {
        logic       inc;                   // Relative (spinner) value present
        logic       abs;                   // Absolute position value
        logic [7:0] p2;
        logic [7:0] p1;
    } analog_out_t;

    localparam logic [7:0] PADDLE_CENTER  = 8'h7f;
    localparam logic [7:0] DPAD_RIGHT_VAL = 8'h40;
    localparam logic [7:0] DPAD_LEFT_VAL  = 8'hc0;

    // Register map, byte addresses
    localparam logic [3:0] REG_DIP_BASE   = 4'h0;
    localparam logic [3:0] REG_ANALOG_CFG = 4'h8;

endpackage

/* apb_config_regs.sv */
`timescale 1ns/1ns
// APB slave holding the DIP switch banks and the analog configuration
// DIP bytes kept active low as downloaded, presented inverted on dsw
module apb_config_regs #(
    parameter int NUM_DIP_BANKS = 2
) (
    input  logic                                               clk_sys,
    input  logic                                               rst,
    input  logic                                               psel,
    input  logic                                               penable,
    input  logic                                               pwrite,
    input  logic [3:0]                                         paddr,
    input  logic [arcade_in_pkg::DIP_W-1:0]                    pwdata,
    output logic [arcade_in_pkg::DIP_W-1:0]                    prdata,
    output logic                                               pready,
    output logic                                               pslverr,
    output logic [NUM_DIP_BANKS-1:0][arcade_in_pkg::DIP_W-1:0] dsw,
    output arcade_in_pkg::analog_cfg_t                         analog_cfg
);

    localparam int CFG_PAD = arcade_in_pkg::DIP_W - $bits(arcade_in_pkg::analog_cfg_t);

    logic [NUM_DIP_BANKS-1:0][arcade_in_pkg::DIP_W-1:0] dip_q;  // Active low
    logic [3:0] dip_off;
    logic       access;
    logic       dip_hit;
    logic       cfg_hit;
    logic       addr_ok;
    logic       wr_en;

    // ========================================
    // Address decode
    // ========================================
    assign access  = psel && penable;     // Access phase
    assign dip_off = paddr - arcade_in_pkg::REG_DIP_BASE;
    assign dip_hit = dip_off < 4'(NUM_DIP_BANKS);
    assign cfg_hit = paddr == arcade_in_pkg::REG_ANALOG_CFG;
    assign addr_ok = dip_hit || cfg_hit;
    assign wr_en   = access && pwrite && addr_ok;

    assign pready  = 1'b1;                // No wait states
    assign pslverr = access && !addr_ok;

    // ========================================
    // Register writes
    // ========================================
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dip_q      <= '1;             // All switches off
            analog_cfg <= '0;
        end else if (wr_en) begin
            if (cfg_hit) begin
                analog_cfg <= arcade_in_pkg::analog_cfg_t'(pwdata[CFG_PAD'(0) +: 6]);
            end
            for (int i = 0; i < NUM_DIP_BANKS; i++) begin
                if (dip_hit && dip_off == 4'(i)) begin
                    dip_q[i] <= pwdata;
                end
            end
        end
    end

    // Readback, only driven in a read access phase
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (cfg_hit) begin
                prdata = {{CFG_PAD{1'b0}}, analog_cfg};
            end
            for (int i = 0; i < NUM_DIP_BANKS; i++) begin
                if (dip_hit && dip_off == 4'(i)) begin
                    prdata = dip_q[i];
                end
            end
        end
    end

    assign dsw = ~dip_q;                  // Active high towards the core

endmodule

/* control_panel.sv */
`timescale 1ns/1ns
// Merges joystick and keyboard into registered player words and the combined word
// Per-player coin pulse stretched over a number of vblank frames
module control_panel #(
    parameter int COIN_PULSE_FRAMES = 2
) (
    input  logic                                                     clk_sys,
    input  logic                                                     rst,
    input  arcade_in_pkg::player_word_t [arcade_in_pkg::NUM_PLAYERS-1:0] joystick,
    input  arcade_in_pkg::kb_player_t   [arcade_in_pkg::NUM_PLAYERS-1:0] kb,
    input  logic                                                     kb_pause,
    input  logic                                                     vblank,
    output arcade_in_pkg::player_word_t [arcade_in_pkg::NUM_PLAYERS-1:0] player,
    output arcade_in_pkg::player_word_t                              combined,
    output logic [arcade_in_pkg::NUM_PLAYERS-1:0]                    start,
    output logic [arcade_in_pkg::NUM_PLAYERS-1:0]                    coin
);

    localparam int NP    = arcade_in_pkg::NUM_PLAYERS;
    localparam int CNT_W = (COIN_PULSE_FRAMES > 1) ? $clog2(COIN_PULSE_FRAMES) : 1;
    localparam logic [CNT_W-1:0] LAST_FRAME = CNT_W'(COIN_PULSE_FRAMES - 1);

    arcade_in_pkg::player_word_t [NP-1:0] merged;
    arcade_in_pkg::player_word_t          merged_or;
    logic [NP-1:0]    coin_prev;          // Coin bit of the registered word, one cycle back
    logic [NP-1:0]    coin_edge;
    logic             vblank_q;
    logic             vblank_rise;
    logic [CNT_W-1:0] frame_cnt [NP];

    // ========================================
    // Joystick / keyboard merge
    // ========================================
    always_comb begin
        merged_or = '0;
        for (int p = 0; p < NP; p++) begin
            merged[p]       = joystick[p];
            merged[p][7:0]  = joystick[p][7:0] | kb[p].btn;
            merged[p][arcade_in_pkg::BTN_START] =
                joystick[p][arcade_in_pkg::BTN_START] | kb[p].start;
            merged[p][arcade_in_pkg::BTN_COIN] =
                joystick[p][arcade_in_pkg::BTN_COIN] | kb[p].coin;
            // Pause key is shared by every player
            merged[p][arcade_in_pkg::BTN_PAUSE] =
                joystick[p][arcade_in_pkg::BTN_PAUSE] | kb_pause;
            merged_or = merged_or | merged[p];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            player   <= '0;
            combined <= '0;
        end else begin
            player   <= merged;
            combined <= merged_or;
        end
    end

    always_comb begin
        for (int p = 0; p < NP; p++) begin
            start[p]     = player[p][arcade_in_pkg::BTN_START];  // Same cycle as player
            coin_edge[p] = player[p][arcade_in_pkg::BTN_COIN] && !coin_prev[p];
        end
    end

    // ========================================
    // Coin pulse
    // ========================================
    assign vblank_rise = vblank && !vblank_q;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            vblank_q  <= 1'b0;
            coin_prev <= '0;
            coin      <= '0;
            for (int p = 0; p < NP; p++) begin
                frame_cnt[p] <= '0;
            end
        end else begin
            vblank_q <= vblank;
            for (int p = 0; p < NP; p++) begin
                coin_prev[p] <= player[p][arcade_in_pkg::BTN_COIN];
                if (!coin[p]) begin
                    if (coin_edge[p]) begin
                        coin[p] <= 1'b1;  // Start pulse, counter already at 0
                    end
                end else if (vblank_rise) begin
                    if (frame_cnt[p] == LAST_FRAME) begin
                        coin[p]      <= 1'b0;
                        frame_cnt[p] <= '0;
                    end else begin
                        frame_cnt[p] <= frame_cnt[p] + 1'b1;
                    end
                end
                // Edges while the pulse is high are dropped
            end
        end
    end

endmodule

/* analog_conditioner.sv */
`timescale 1ns/1ns
// Analog source select (stick, paddle, spinner, d-pad) for players 1 and 2
// with sensitivity scaling and inversion, registered every cycle
module analog_conditioner (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  arcade_in_pkg::analog_cfg_t  cfg,
    input  arcade_in_pkg::analog_src_t  src_p1,
    input  arcade_in_pkg::analog_src_t  src_p2,
    input  arcade_in_pkg::player_word_t player_p1,
    input  arcade_in_pkg::player_word_t player_p2,
    output arcade_in_pkg::analog_out_t  aout
);

    logic [1:0] spin_prev;                // Previous spinner bit 8, {p2, p1}
    logic [1:0] spin_tgl;
    logic [7:0] p1_d;
    logic [7:0] p2_d;
    logic       abs_d;
    logic       inc_d;
    logic [7:0] p1_q;
    logic [7:0] p2_q;
    logic       abs_q;
    logic       inc_q;

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [7:0] scale(input logic [7:0] d, input logic [2:0] s,
                                         input logic inv);
        logic signed [7:0] ds;
        logic [7:0]        r;
        ds = d;
        unique case (s)
            3'd0: r = d;                   // 100%
            3'd1: r = ds >>> 1;            // 50%
            3'd2: r = ds >>> 2;
            3'd3: r = ds >>> 3;
            3'd4: r = ds >>> 4;            // 6%
            3'd5: r = d + d;               // 200%, wraps
            3'd6: r = d + 8'(ds >>> 1);
            3'd7: r = d + 8'(ds >>> 2);    // 125%
        endcase
        // Zero stays zero when inverted
        return (inv && r != 8'h00) ? ~r : r;
    endfunction

    function automatic logic [7:0] dpad(input arcade_in_pkg::player_word_t w);
        if (w[arcade_in_pkg::DIR_RIGHT]) begin
            return arcade_in_pkg::DPAD_RIGHT_VAL;
        end else if (w[arcade_in_pkg::DIR_LEFT]) begin
            return arcade_in_pkg::DPAD_LEFT_VAL;
        end
        return 8'h00;
    endfunction

    // ========================================
    // Source select
    // ========================================
    assign spin_tgl = {src_p2.spinner[8], src_p1.spinner[8]} ^ spin_prev;

    always_comb begin
        p1_d  = 8'h00;
        p2_d  = 8'h00;
        abs_d = 1'b0;
        inc_d = 1'b0;
        unique case (cfg.mode)
            arcade_in_pkg::ANA_STICK: begin
                p1_d  = scale(src_p1.stick_x, cfg.sens, cfg.invert);
                p2_d  = scale(src_p2.stick_x, cfg.sens, cfg.invert);
                abs_d = 1'b1;
            end
            arcade_in_pkg::ANA_PADDLE: begin
                p1_d  = scale(src_p1.paddle - arcade_in_pkg::PADDLE_CENTER,
                              cfg.sens, cfg.invert);
                p2_d  = scale(src_p2.paddle - arcade_in_pkg::PADDLE_CENTER,
                              cfg.sens, cfg.invert);
                abs_d = 1'b1;
            end
            arcade_in_pkg::ANA_SPINNER: begin
                if (spin_tgl[0]) begin     // New delta from player 1
                    p1_d  = scale(src_p1.spinner[7:0], cfg.sens, cfg.invert);
                    inc_d = 1'b1;
                end
                if (spin_tgl[1]) begin
                    p2_d  = scale(src_p2.spinner[7:0], cfg.sens, cfg.invert);
                    inc_d = 1'b1;
                end
            end
            arcade_in_pkg::ANA_DPAD: begin
                p1_d  = scale(dpad(player_p1), cfg.sens, cfg.invert);
                p2_d  = scale(dpad(player_p2), cfg.sens, cfg.invert);
                abs_d = 1'b1;
            end
        endcase
    end

    // Value registers
    always_ff @(posedge clk_sys) begin
        p1_q <= p1_d;
        p2_q <= p2_d;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            spin_prev <= 2'b00;
            abs_q     <= 1'b0;
            inc_q     <= 1'b0;
        end else begin
            spin_prev <= {src_p2.spinner[8], src_p1.spinner[8]};
            abs_q     <= abs_d;
            inc_q     <= inc_d;
        end
    end

    assign aout = '{inc: inc_q, abs: abs_q, p2: p2_q, p1: p1_q};

endmodule

/* arcade_input_top.sv */
`timescale 1ns/1ns
// Player-input front end top: APB config, control panel, analog conditioner
module arcade_input_top #(
    parameter int COIN_PULSE_FRAMES = 2,  // Frames a coin pulse lasts
    parameter int NUM_DIP_BANKS     = 2
) (
    input  logic                                                     clk_sys,
    input  logic                                                     rst,
    // APB slave
    input  logic                                                     psel,
    input  logic                                                     penable,
    input  logic                                                     pwrite,
    input  logic [3:0]                                               paddr,
    input  logic [arcade_in_pkg::DIP_W-1:0]                          pwdata,
    output logic [arcade_in_pkg::DIP_W-1:0]                          prdata,
    output logic                                                     pready,
    output logic                                                     pslverr,
    // Player inputs
    input  arcade_in_pkg::player_word_t [arcade_in_pkg::NUM_PLAYERS-1:0] joystick,
    input  arcade_in_pkg::kb_player_t   [arcade_in_pkg::NUM_PLAYERS-1:0] kb,
    input  logic                                                     kb_pause,
    input  logic                                                     vblank,
    input  arcade_in_pkg::analog_src_t                               src_p1,
    input  arcade_in_pkg::analog_src_t                               src_p2,
    // To the core
    output arcade_in_pkg::player_word_t [arcade_in_pkg::NUM_PLAYERS-1:0] player,
    output arcade_in_pkg::player_word_t                              combined,
    output logic [arcade_in_pkg::NUM_PLAYERS-1:0]                    start,
    output logic [arcade_in_pkg::NUM_PLAYERS-1:0]                    coin,
    output arcade_in_pkg::analog_out_t                               aout,
    output logic [NUM_DIP_BANKS-1:0][arcade_in_pkg::DIP_W-1:0]       dsw
);

    arcade_in_pkg::analog_cfg_t analog_cfg;

    apb_config_regs #(
        .NUM_DIP_BANKS(NUM_DIP_BANKS)
    ) i_regs (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .dsw        (dsw),
        .analog_cfg (analog_cfg)
    );

    control_panel #(
        .COIN_PULSE_FRAMES(COIN_PULSE_FRAMES)
    ) i_panel (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .joystick (joystick),
        .kb       (kb),
        .kb_pause (kb_pause),
        .vblank   (vblank),
        .player   (player),
        .combined (combined),
        .start    (start),
        .coin     (coin)
    );

    // D-pad mode reads the registered words of players 1 and 2
    analog_conditioner i_analog (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .cfg       (analog_cfg),
        .src_p1    (src_p1),
        .src_p2    (src_p2),
        .player_p1 (player[0]),
        .player_p2 (player[1]),
        .aout      (aout)
    );

endmodule

/* arcade_input_checker.sv */
`timescale 1ns/1ns
// Concurrent assertions on the APB handshake and the coin pulse rise
// Bound into apb_config_regs and control_panel
module arcade_input_checker #(
    parameter bit CHECK_APB  = 1'b1,      // APB rules apply to the bound module
    parameter bit CHECK_COIN = 1'b1
) (
    input logic                                                     clk_sys,
    input logic                                                     rst,
    input logic                                                     psel,
    input logic                                                     penable,
    input logic                                                     pready,
    input logic                                                     pslverr,
    input arcade_in_pkg::player_word_t [arcade_in_pkg::NUM_PLAYERS-1:0] player,
    input logic [arcade_in_pkg::NUM_PLAYERS-1:0]                    coin
);

    // ========================================
    // APB
    // ========================================
    if (CHECK_APB) begin : g_apb
        a_pready: assert property (@(posedge clk_sys) disable iff (rst) pready)
            else $error("pready went low, wait states are not expected");

        a_pslverr: assert property (@(posedge clk_sys) disable iff (rst)
            pslverr |-> (psel && penable))
            else $error("pslverr raised outside an access phase");
    end

    // Coin output only rises one cycle after the registered coin bit rose
    if (CHECK_COIN) begin : g_coin
        for (genvar p = 0; p < arcade_in_pkg::NUM_PLAYERS; p++) begin : g_player
            a_coin_rise: assert property (@(posedge clk_sys) disable iff (rst)
                $rose(coin[p]) |-> ($past(player[p][arcade_in_pkg::BTN_COIN])
                    && !$past(player[p][arcade_in_pkg::BTN_COIN], 2)))
                else $error("coin %0d rose without a coin edge", p);
        end
    end

endmodule

bind apb_config_regs arcade_input_checker #(
    .CHECK_APB (1'b1),
    .CHECK_COIN(1'b0)
) i_apb_chk (
    .clk_sys(clk_sys), .rst(rst), .psel(psel), .penable(penable),
    .pready(pready), .pslverr(pslverr), .player('0), .coin('0)
);

bind control_panel arcade_input_checker #(
    .CHECK_APB (1'b0),
    .CHECK_COIN(1'b1)
) i_coin_chk (
    .clk_sys(clk_sys), .rst(rst), .psel(1'b0), .penable(1'b0),
    .pready(1'b1), .pslverr(1'b0), .player(player), .coin(coin)
);

/* tb_arcade_input.sv */
`timescale 1ns/1ns
// Testbench for the arcade player-input front end
// APB tasks, random stimulus, reference model and a per-cycle compare process
module tb_arcade_input;

    localparam int NP            = arcade_in_pkg::NUM_PLAYERS;
    localparam int COIN_FRAMES   = 2;
    localparam int NUM_DIP_BANKS = 2;
    localparam int MAX_CYCLES    = 3000;   // Tests take about 900 cycles

    logic clk_sys, rst, psel, penable, pwrite, pready, pslverr, kb_pause, vblank;
    logic [3:0] paddr;
    logic [7:0] pwdata, prdata;
    arcade_in_pkg::player_word_t [NP-1:0] joystick, player, h_joy, exp_player, exp_player_q;
    arcade_in_pkg::kb_player_t   [NP-1:0] kb, h_kb;
    arcade_in_pkg::player_word_t combined, exp_combined;
    arcade_in_pkg::analog_src_t  src_p1, src_p2, h_src1, h_src2;
    arcade_in_pkg::analog_cfg_t  model_cfg, h_cfg;
    arcade_in_pkg::analog_out_t  aout, exp_aout;
    logic [NP-1:0] start, coin, exp_start;
    logic [NUM_DIP_BANKS-1:0][7:0] dsw;
    logic [7:0] model_dip [NUM_DIP_BANKS];
    logic [1:0] h_spin;                    // Spinner bit 8 two cycles back, {p2, p1}
    logic       h_pause, chk_on;
    int seed, errors, checks, cycles;

    arcade_input_top #(
        .COIN_PULSE_FRAMES(COIN_FRAMES),
        .NUM_DIP_BANKS    (NUM_DIP_BANKS)
    ) i_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    // ========================================
    // Reference model
    // ========================================
    function automatic arcade_in_pkg::player_word_t merge_ref(
        input arcade_in_pkg::player_word_t joy, input arcade_in_pkg::kb_player_t k,
        input logic pause);
        arcade_in_pkg::player_word_t kw;
        kw = '0;
        kw[7:0] = k.btn;
        kw[arcade_in_pkg::BTN_START] = k.start;
        kw[arcade_in_pkg::BTN_COIN]  = k.coin;
        kw[arcade_in_pkg::BTN_PAUSE] = pause;  // Shared key
        return joy | kw;
    endfunction

    function automatic logic [7:0] scale_ref(input logic [7:0] d, input logic [2:0] s,
                                             input logic inv);
        int         v;
        logic [7:0] r;
        v = int'($signed(d));
        case (s)
            3'd5:    v = 2 * v;
            3'd6:    v = v + (v >>> 1);
            3'd7:    v = v + (v >>> 2);
            default: v = v >>> s;          // 0 to 4 are plain shifts
        endcase
        r = 8'(v);
        return (inv && r != 8'h00) ? ~r : r;
    endfunction

    function automatic logic [7:0] dpad_ref(input arcade_in_pkg::player_word_t w);
        if (w[arcade_in_pkg::DIR_RIGHT]) return arcade_in_pkg::DPAD_RIGHT_VAL;
        if (w[arcade_in_pkg::DIR_LEFT]) return arcade_in_pkg::DPAD_LEFT_VAL;
        return 8'h00;
    endfunction

    function automatic arcade_in_pkg::analog_out_t analog_ref(
        input arcade_in_pkg::analog_cfg_t c, input arcade_in_pkg::analog_src_t s1, s2,
        input logic [1:0] spin_q, input arcade_in_pkg::player_word_t w1, w2);
        arcade_in_pkg::analog_out_t r;
        r = '0;
        r.abs = (c.mode != arcade_in_pkg::ANA_SPINNER);
        case (c.mode)
            arcade_in_pkg::ANA_STICK: begin
                r.p1 = scale_ref(s1.stick_x, c.sens, c.invert);
                r.p2 = scale_ref(s2.stick_x, c.sens, c.invert);
            end
            arcade_in_pkg::ANA_PADDLE: begin
                r.p1 = scale_ref(8'(s1.paddle - arcade_in_pkg::PADDLE_CENTER), c.sens, c.invert);
                r.p2 = scale_ref(8'(s2.paddle - arcade_in_pkg::PADDLE_CENTER), c.sens, c.invert);
            end
            arcade_in_pkg::ANA_SPINNER: begin
                if (s1.spinner[8] != spin_q[0])
                    r.p1 = scale_ref(s1.spinner[7:0], c.sens, c.invert);
                if (s2.spinner[8] != spin_q[1])
                    r.p2 = scale_ref(s2.spinner[7:0], c.sens, c.invert);
                r.inc = (s1.spinner[8] != spin_q[0]) || (s2.spinner[8] != spin_q[1]);
            end
            default: begin
                r.p1 = scale_ref(dpad_ref(w1), c.sens, c.invert);
                r.p2 = scale_ref(dpad_ref(w2), c.sens, c.invert);
            end
        endcase
        return r;
    endfunction

    function automatic logic addr_err(input logic [3:0] a);
        return !(a < 4'(NUM_DIP_BANKS) || a == arcade_in_pkg::REG_ANALOG_CFG);
    endfunction

    function automatic logic [7:0] read_ref(input logic [3:0] a);
        if (a == arcade_in_pkg::REG_ANALOG_CFG) return {2'b00, model_cfg};
        if (a < 4'(NUM_DIP_BANKS)) return model_dip[int'(a)];
        return 8'h00;
    endfunction

    // ========================================
    // Checks and bus tasks
    // ========================================
    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            #5;                            // Drive after the edge
        end
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] a, input logic [7:0] d,
                              output logic [7:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        step_cycles(1);
        penable = 1'b1;                    // Access phase
        @(negedge clk_sys);
        while (!pready) @(negedge clk_sys);
        rdata = prdata;
        err   = pslverr;
        step_cycles(1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
        logic [7:0] unused_rd;
        logic       err;
        apb_access(1'b1, a, d, unused_rd, err);
        check_value("pslverr on write", 32'(err), 32'(addr_err(a)));
        if (!addr_err(a) && a == arcade_in_pkg::REG_ANALOG_CFG) model_cfg = d[5:0];
        else if (!addr_err(a)) model_dip[int'(a)] = d;
    endtask

    task automatic check_reg(input logic [3:0] a);
        logic [7:0] rd;
        logic       err;
        apb_access(1'b0, a, 8'h00, rd, err);
        check_value($sformatf("readback of 0x%h", a), 32'(rd), 32'(read_ref(a)));
        check_value("pslverr on read", 32'(err), 32'(addr_err(a)));
    endtask

    task automatic check_all_regs();
        for (int b = 0; b < NUM_DIP_BANKS; b++) begin
            check_reg(4'(b));
            check_value($sformatf("dsw bank %0d", b), 32'(dsw[b]), {24'h0, ~model_dip[b]});
        end
        check_reg(arcade_in_pkg::REG_ANALOG_CFG);
    endtask

    task automatic clear_inputs();
        joystick = '0;
        kb       = '0;
        kb_pause = 1'b0;
        vblank   = 1'b0;
        src_p1   = '0;
        src_p2   = '0;
    endtask

    task automatic drive_random_inputs();
        for (int p = 0; p < NP; p++) begin
            joystick[p] = 16'($random(seed));
            kb[p]       = arcade_in_pkg::kb_player_t'(10'($random(seed)));
        end
        kb_pause = 1'($random(seed));
        src_p1   = arcade_in_pkg::analog_src_t'(25'($random(seed)));
        src_p2   = arcade_in_pkg::analog_src_t'(25'($random(seed)));
    endtask

    task automatic sweep_random(input logic [1:0] mode);
        for (int s = 0; s < 8; s++) begin
            for (int i = 0; i < 2; i++) begin
                write_reg(arcade_in_pkg::REG_ANALOG_CFG, {2'b00, 1'(i), 3'(s), mode});
                repeat (8) begin
                    drive_random_inputs();
                    step_cycles(1);
                end
            end
        end
    endtask

    task automatic vblank_pulse();
        vblank = 1'b1;
        step_cycles(1);
        vblank = 1'b0;
        step_cycles(2);
    endtask

    // ========================================
    // Compare process, outputs against inputs one cycle back
    // ========================================
    always @(negedge clk_sys) begin
        exp_combined = '0;
        for (int p = 0; p < NP; p++) begin
            exp_player[p] = merge_ref(h_joy[p], h_kb[p], h_pause);
            exp_combined  = exp_combined | exp_player[p];
            exp_start[p]  = exp_player[p][arcade_in_pkg::BTN_START];
        end
        // D-pad reads last cycle's registered words
        exp_aout = analog_ref(h_cfg, h_src1, h_src2, h_spin, exp_player_q[0], exp_player_q[1]);
        if (chk_on) begin
            for (int p = 0; p < NP; p++) begin
                check_value($sformatf("player %0d word", p), 32'(player[p]), 32'(exp_player[p]));
            end
            check_value("combined word", 32'(combined), 32'(exp_combined));
            check_value("start vector", 32'(start), 32'(exp_start));
            check_value("analog out", 32'(aout), 32'(exp_aout));
        end
        h_spin       = {h_src2.spinner[8], h_src1.spinner[8]};
        exp_player_q = exp_player;
        h_joy        = joystick;
        h_kb         = kb;
        h_pause      = kb_pause;
        h_src1       = src_p1;
        h_src2       = src_p2;
        h_cfg        = model_cfg;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("ERROR: timeout, the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Counts: %0d checks, %0d errors", checks, errors);
        $display("Checks failed");
        $finish;
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        seed    = 32'hd412c032;
        errors  = 0;
        checks  = 0;
        chk_on  = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        clear_inputs();
        model_cfg = '0;
        for (int b = 0; b < NUM_DIP_BANKS; b++) model_dip[b] = 8'hff;
        step_cycles(3);
        rst = 1'b0;
        step_cycles(2);
        chk_on = 1'b1;

        repeat (150) begin                 // Merge of joystick, keyboard and pause
            drive_random_inputs();
            step_cycles(1);
        end
        clear_inputs();

        check_all_regs();
        for (int b = 0; b < NUM_DIP_BANKS; b++) begin
            write_reg(arcade_in_pkg::REG_DIP_BASE + 4'(b), 8'($random(seed)));
        end
        write_reg(arcade_in_pkg::REG_ANALOG_CFG, 8'h2d);
        check_all_regs();
        write_reg(4'h9, 8'h00);            // Out of map, must change nothing
        check_reg(4'h9);
        check_all_regs();

        sweep_random(arcade_in_pkg::ANA_STICK);
        sweep_random(arcade_in_pkg::ANA_PADDLE);
        sweep_random(arcade_in_pkg::ANA_SPINNER);

        for (int s = 0; s < 8; s++) begin
            for (int i = 0; i < 2; i++) begin
                write_reg(arcade_in_pkg::REG_ANALOG_CFG,
                          {2'b00, 1'(i), 3'(s), arcade_in_pkg::ANA_DPAD});
                clear_inputs();
                joystick[0][arcade_in_pkg::DIR_RIGHT] = 1'b1;
                joystick[1][arcade_in_pkg::DIR_LEFT]  = 1'b1;
                step_cycles(3);
                joystick[0] = 16'h0002;
                joystick[1] = 16'h0001;
                step_cycles(3);
                clear_inputs();
                step_cycles(3);
            end
        end

        // Coin pulse, any pulse left from random stimulus expires first
        step_cycles(2);
        repeat (COIN_FRAMES + 1) vblank_pulse();
        check_value("coin idle", 32'(coin), 32'(0));
        joystick[0][arcade_in_pkg::BTN_COIN] = 1'b1;
        step_cycles(1);
        check_value("coin before edge", 32'(coin[0]), 32'(0));
        step_cycles(1);
        check_value("coin after edge", 32'(coin[0]), 32'(1));
        repeat (COIN_FRAMES - 1) vblank_pulse();
        joystick[0][arcade_in_pkg::BTN_COIN] = 1'b0;
        step_cycles(2);
        joystick[0][arcade_in_pkg::BTN_COIN] = 1'b1;   // Second press during the pulse
        step_cycles(3);
        check_value("coin held", 32'(coin[0]), 32'(1));
        vblank = 1'b1;
        step_cycles(1);
        check_value("coin after last frame", 32'(coin[0]), 32'(0));
        vblank = 1'b0;
        step_cycles(4);
        check_value("coin stays low", 32'(coin[0]), 32'(0));
        clear_inputs();
        step_cycles(2);

        $display("Counts: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* flist.f */
arcade_in_pkg.sv
apb_config_regs.sv
control_panel.sv
analog_conditioner.sv
arcade_input_top.sv
arcade_input_checker.sv
tb_arcade_input.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the arcade input testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_arcade_input \
    -f flist.f \
    -o sim_tb_arcade_input

./obj_dir/sim_tb_arcade_input > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
